// ==== all.f ====
+incdir+hw
hw/rv_pkg.sv
hw/ctrl.sv
hw/imm_gen.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_reg.sv
hw/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module alu (
    input  rv_pkg::alu_op_e     alu_op,
    input  rv_pkg::alu_src_e    alu_src,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;

    always_comb begin
        op_a = rs1_data;
        op_b = rs2_data;
        case (alu_src)
            rv_pkg::src_imm:     op_b = imm;
            rv_pkg::src_four_pc: begin
                op_a = pc;
                op_b = `RV_XLEN'd4;
            end
            rv_pkg::src_pc_imm:  begin
                op_a = pc;
                op_b = imm;
            end
            default: ;  // src_reg
        endcase
    end

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add: result = op_a + op_b;  // wraps at 32 bits
            rv_pkg::alu_sub: result = op_a - op_b;
            rv_pkg::alu_and: result = op_a & op_b;
            default:         result = '0;
        endcase
    end

    assign zero = (result == '0);  // bne taken when low

endmodule

// ==== hw/ctrl.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module ctrl (
    input  logic [`RV_XLEN-1:0] inst,
    output rv_pkg::ctrl_t       ctrl,
    output logic                halt_req,
    output logic                illegal
);

    rv_pkg::opcode_e       opcode;
    rv_pkg::funct3_e       funct3;
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;

    assign opcode = rv_pkg::opcode_e'(inst[6:0]);
    assign funct3 = rv_pkg::funct3_e'(inst[`RV_FUNCT3_BASE +: 3]);
    assign funct7 = inst[`RV_FUNCT7_BASE +: 7];
    assign rd     = inst[`RV_RD_BASE +: `RV_REG_AW];
    assign rs1    = inst[`RV_RS1_BASE +: `RV_REG_AW];
    assign rs2    = inst[`RV_RS2_BASE +: `RV_REG_AW];

    always_comb begin
        // and-op, I immediate, register source, nothing enabled
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.reg_wen    = 1'b0;
        ctrl.reg_waddr  = '0;
        ctrl.reg1_raddr = '0;
        ctrl.reg2_raddr = '0;
        ctrl.imm_op     = rv_pkg::imm_i;
        ctrl.alu_op     = rv_pkg::alu_and;
        ctrl.alu_src    = rv_pkg::src_reg;
        halt_req        = 1'b0;
        illegal         = 1'b0;

        case (opcode)
            rv_pkg::r_type: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.alu_src    = rv_pkg::src_reg;
                if (funct3 == rv_pkg::add_sub) begin
                    case (funct7)
                        rv_pkg::funct7_add: ctrl.alu_op = rv_pkg::alu_add;
                        rv_pkg::funct7_sub: ctrl.alu_op = rv_pkg::alu_sub;
                        default:            illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_pkg::i_type: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.alu_src    = rv_pkg::src_imm;
                if (funct3 == rv_pkg::add_sub) begin  // addi
                    ctrl.alu_op = rv_pkg::alu_add;
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_pkg::b_type: begin
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.imm_op     = rv_pkg::imm_b;
                ctrl.alu_src    = rv_pkg::src_reg;
                if (funct3 == rv_pkg::bne) begin
                    ctrl.branch = 1'b1;
                    ctrl.alu_op = rv_pkg::alu_sub;  // zero flag is the compare
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_pkg::jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.imm_op    = rv_pkg::imm_j;  // target offset for pc_reg
                ctrl.alu_op    = rv_pkg::alu_add;
                ctrl.alu_src   = rv_pkg::src_four_pc;  // link value
            end
            rv_pkg::lui: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = '0;  // x0 + imm
                ctrl.imm_op     = rv_pkg::imm_u;
                ctrl.alu_op     = rv_pkg::alu_add;
                ctrl.alu_src    = rv_pkg::src_imm;
            end
            rv_pkg::auipc: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.imm_op    = rv_pkg::imm_u;
                ctrl.alu_op    = rv_pkg::alu_add;
                ctrl.alu_src   = rv_pkg::src_pc_imm;
            end
            rv_pkg::system: begin
                if (inst == rv_pkg::ebreak_inst) begin
                    halt_req = 1'b1;
                end else begin
                    illegal = 1'b1;  // ecall, csr ops not supported
                end
            end
            default: illegal = 1'b1;
        endcase

        // an unknown encoding writes no register
        if (illegal) begin
            ctrl.reg_wen = 1'b0;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0] inst,
    input  rv_pkg::imm_op_e     imm_op,
    output logic [`RV_XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_op)
            rv_pkg::imm_i: imm = {{20{sign}}, inst[31:20]};
            rv_pkg::imm_b: begin
                // offset is in halfwords, bit 0 always zero
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            rv_pkg::imm_j: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            rv_pkg::imm_u: imm = {inst[31:12], 12'b0};  // upper 20 bits
            default:       imm = '0;
        endcase
    end

endmodule

// ==== hw/pc_reg.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module pc_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                branch,
    input  logic                jump,
    input  logic                zero,
    input  logic                halt_req,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] pc,
    output logic                halted
);

    logic                taken;
    logic [`RV_XLEN-1:0] next_pc;

    // bne taken when operands differ, jal always
    assign taken   = (branch && !zero) || jump;
    assign next_pc = taken ? (pc + imm) : (pc + `RV_XLEN'd4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (!halted) begin  // frozen once halted
            pc <= next_pc;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  rv_pkg::wb_t           wb
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && (wb.waddr != '0)) begin  // x0 is never written
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // reads bypass nothing, write lands at the clock edge
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] inst,  // returned combinationally for pc
    output rv_pkg::wb_t         wb,
    output logic                illegal,
    output logic                halted
);

    rv_pkg::ctrl_t       dec;
    logic                halt_req;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;
    logic [`RV_XLEN-1:0] alu_result;
    logic                zero;

    ctrl i_ctrl (
        .inst     (inst),
        .ctrl     (dec),
        .halt_req (halt_req),
        .illegal  (illegal)
    );

    imm_gen i_imm_gen (
        .inst   (inst),
        .imm_op (dec.imm_op),
        .imm    (imm)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.reg1_raddr),
        .raddr2 (dec.reg2_raddr),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    alu i_alu (
        .alu_op   (dec.alu_op),
        .alu_src  (dec.alu_src),
        .rs1_data (rdata1),
        .rs2_data (rdata2),
        .pc       (pc),
        .imm      (imm),
        .result   (alu_result),
        .zero     (zero)
    );

    pc_reg i_pc_reg (
        .clk      (clk),
        .reset    (reset),
        .branch   (dec.branch),
        .jump     (dec.jump),
        .zero     (zero),
        .halt_req (halt_req),
        .imm      (imm),
        .pc       (pc),
        .halted   (halted)
    );

    // write-back, blocked after ebreak
    assign wb.wen   = dec.reg_wen & ~halted;
    assign wb.waddr = dec.reg_waddr;
    assign wb.wdata = alu_result;

endmodule

// ==== hw/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data path and instruction width
`define RV_XLEN        32

// register file geometry
`define RV_REG_AW      5
`define RV_REG_NUM     32

// bit positions of the instruction fields
`define RV_RD_BASE     7
`define RV_RS1_BASE    15
`define RV_RS2_BASE    20
`define RV_FUNCT3_BASE 12
`define RV_FUNCT7_BASE 25

// first fetch address after reset
`define RV_RESET_PC    32'h0000_0000

`endif

// ==== hw/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        r_type = 7'b0110011,
        i_type = 7'b0010011,
        b_type = 7'b1100011,
        jal    = 7'b1101111,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        system = 7'b1110011
    } opcode_e;

    // add_sub also covers addi, same funct3
    typedef enum logic [2:0] {
        add_sub = 3'b000,
        bne     = 3'b001
    } funct3_e;

    localparam logic [6:0] funct7_add = 7'b0000000;
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // only legal system encoding
    localparam logic [`RV_XLEN-1:0] ebreak_inst = 32'h0010_0073;

    typedef enum logic [1:0] {
        alu_and = 2'd0,
        alu_add = 2'd1,
        alu_sub = 2'd2
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_b = 2'd1,
        imm_j = 2'd2,
        imm_u = 2'd3
    } imm_op_e;

    typedef enum logic [1:0] {
        src_reg     = 2'd0,  // rs1, rs2
        src_imm     = 2'd1,  // rs1, imm
        src_four_pc = 2'd2,  // pc, 4
        src_pc_imm  = 2'd3   // pc, imm
    } alu_src_e;

    typedef struct packed {
        logic                  branch;
        logic                  jump;
        logic                  reg_wen;
        logic [`RV_REG_AW-1:0] reg_waddr;
        logic [`RV_REG_AW-1:0] reg1_raddr;
        logic [`RV_REG_AW-1:0] reg2_raddr;
        imm_op_e               imm_op;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
    } ctrl_t;

    typedef struct packed {
        logic                  wen;
        logic [`RV_REG_AW-1:0] waddr;
        logic [`RV_XLEN-1:0]   wdata;
    } wb_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_core_tb -f all.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/rv_core_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== sim/rv_core_checker.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core_checker (
    input logic                clk,
    input logic                reset,
    input logic [`RV_XLEN-1:0] pc,
    input rv_pkg::wb_t         wb,
    input logic                illegal,
    input logic                halted
);

    int fail_count = 0;  // read back by the testbench

    no_write_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !wb.wen)
        else begin
            fail_count++;
            $error("register write enabled while halted");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc not word aligned");
        end

    // an illegal encoding never reaches the register file
    no_write_illegal: assert property (@(posedge clk) disable iff (reset) !(illegal && wb.wen))
        else begin
            fail_count++;
            $error("register write enabled on an illegal instruction");
        end

    pc_frozen: assert property (@(posedge clk) disable iff (reset)
        (halted && $past(halted)) |-> $stable(pc))
        else begin
            fail_count++;
            $error("pc moved while halted");
        end

endmodule

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_core_tb;

    localparam int reset_cycles = 8;
    localparam int max_cycles   = 2000;  // far above the ~110 cycles all tests take

    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] inst;
    rv_pkg::wb_t         wb;
    logic                illegal;
    logic                halted;

    logic [`RV_XLEN-1:0] prog_mem [0:255];
    logic [`RV_XLEN-1:0] model_regs [0:`RV_REG_NUM-1];
    logic [`RV_XLEN-1:0] model_pc;
    logic                model_halted;
    int                  error_count;
    int                  cycle_count = 0;

    rv_core i_dut (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .inst    (inst),
        .wb      (wb),
        .illegal (illegal),
        .halted  (halted)
    );

    bind rv_core rv_core_checker i_checker (.*);

    assign inst = prog_mem[pc[9:2]];  // combinational fetch

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_pkg::i_type};
    endfunction

    function automatic logic [31:0] alu_inst(input logic [6:0] f7, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, rv_pkg::r_type};
    endfunction

    function automatic logic [31:0] bne_inst(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], rv_pkg::b_type};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::jal};
    endfunction

    function automatic logic [31:0] upper_inst(input rv_pkg::opcode_e op, input logic [4:0] rd,
                                               input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // unused words hold an illegal opcode tagged with their index
    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog_mem[i] = {17'h0, i[7:0], 7'h7f};
        end
    endtask

    // architectural step of one instruction at model_pc
    task automatic model_step(output rv_pkg::wb_t exp_wb, output logic exp_ill);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] next_pc;
        logic        wr;
        logic        halt_now;
        ins          = prog_mem[model_pc[9:2]];
        a            = model_regs[ins[19:15]];
        b            = model_regs[ins[24:20]];
        next_pc      = model_pc + 32'd4;
        exp_wb       = '0;
        exp_wb.waddr = ins[11:7];
        exp_ill      = 1'b0;
        wr           = 1'b0;
        halt_now     = 1'b0;
        case (ins[6:0])
            7'b0110011: begin  // add, sub
                wr = (ins[14:12] == 3'b000) && (ins[31:25] == 7'h00 || ins[31:25] == 7'h20);
                exp_ill = !wr;
                exp_wb.wdata = ins[30] ? a - b : a + b;
            end
            7'b0010011: begin  // addi
                wr = (ins[14:12] == 3'b000);
                exp_ill = !wr;
                exp_wb.wdata = a + {{20{ins[31]}}, ins[31:20]};
            end
            7'b1100011: begin  // bne
                exp_ill = (ins[14:12] != 3'b001);
                if (!exp_ill && a != b)
                    next_pc = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
            end
            7'b1101111: begin  // jal
                wr = 1'b1;
                exp_wb.wdata = model_pc + 32'd4;
                next_pc = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            7'b0110111: begin  // lui
                wr = 1'b1;
                exp_wb.wdata = {ins[31:12], 12'b0};
            end
            7'b0010111: begin  // auipc
                wr = 1'b1;
                exp_wb.wdata = model_pc + {ins[31:12], 12'b0};
            end
            7'b1110011: begin
                halt_now = (ins == 32'h0010_0073);  // only ebreak
                exp_ill = !halt_now;
            end
            default: exp_ill = 1'b1;
        endcase
        exp_wb.wen = wr && !model_halted;
        if (!model_halted) begin
            if (wr && ins[11:7] != 5'd0)
                model_regs[ins[11:7]] = exp_wb.wdata;
            model_pc     = next_pc;
            model_halted = halt_now;
        end
    endtask

    task automatic check_wb(input string name, input rv_pkg::wb_t exp, input rv_pkg::wb_t act);
        // address and data only matter when a write is expected
        if (exp.wen ? (act !== exp) : (act.wen !== 1'b0)) begin
            error_count++;
            $display("[FAIL] %s wb: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input logic [`RV_XLEN-1:0] exp,
                            input logic [`RV_XLEN-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s pc: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_cycle(input string name);
        rv_pkg::wb_t exp_wb;
        logic        exp_ill;
        logic        exp_halted;
        exp_halted = model_halted;
        check_pc(name, model_pc, pc);
        model_step(exp_wb, exp_ill);
        check_wb(name, exp_wb, wb);
        check_flag({name, " illegal"}, exp_ill, illegal);
        check_flag({name, " halted"}, exp_halted, halted);
    endtask

    task automatic begin_test();
        @(negedge clk);
        reset = 1'b1;
        clear_program();
        model_pc     = `RV_RESET_PC;
        model_halted = 1'b0;
        for (int i = 0; i < `RV_REG_NUM; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic release_reset();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic run_steps(input string name, input int steps);
        for (int k = 0; k < steps; k++) begin
            check_cycle(name);
            @(negedge clk);
        end
        check_pc(name, model_pc, pc);  // target of the last instruction
    endtask

    task automatic test_arith();
        logic [31:0] rnd1;
        logic [31:0] rnd2;
        rnd1 = $urandom();
        rnd2 = $urandom();
        begin_test();
        prog_mem[0] = addi_inst(5'd1, 5'd0, rnd1[11:0]);
        prog_mem[1] = addi_inst(5'd2, 5'd0, rnd2[11:0]);
        prog_mem[2] = alu_inst(rv_pkg::funct7_add, 5'd3, 5'd1, 5'd2);
        prog_mem[3] = alu_inst(rv_pkg::funct7_sub, 5'd4, 5'd1, 5'd2);
        prog_mem[4] = alu_inst(rv_pkg::funct7_sub, 5'd5, 5'd2, 5'd1);
        prog_mem[5] = addi_inst(5'd7, 5'd0, 12'hfff);  // -1
        prog_mem[6] = alu_inst(rv_pkg::funct7_add, 5'd8, 5'd7, 5'd1);
        prog_mem[7] = addi_inst(5'd0, 5'd1, 12'd5);  // x0 must stay zero
        prog_mem[8] = alu_inst(rv_pkg::funct7_add, 5'd6, 5'd0, 5'd0);
        release_reset();
        run_steps("arith", 9);
    endtask

    task automatic test_upper();
        logic [31:0] rnd1;
        logic [31:0] rnd2;
        rnd1 = $urandom();
        rnd2 = $urandom();
        begin_test();
        prog_mem[0] = upper_inst(rv_pkg::lui, 5'd1, rnd1[19:0]);
        prog_mem[1] = upper_inst(rv_pkg::auipc, 5'd2, rnd2[19:0]);
        prog_mem[2] = upper_inst(rv_pkg::auipc, 5'd3, 20'hfffff);
        release_reset();
        run_steps("upper", 3);
    endtask

    task automatic test_jump();
        begin_test();
        prog_mem[0] = addi_inst(5'd1, 5'd0, 12'd1);
        prog_mem[1] = jal_inst(5'd2, 21'd12);
        prog_mem[2] = addi_inst(5'd3, 5'd0, 12'd3);
        prog_mem[3] = jal_inst(5'd5, 21'd16);
        prog_mem[4] = jal_inst(5'd4, -21'd8);  // backward
        prog_mem[7] = addi_inst(5'd6, 5'd0, 12'd6);
        release_reset();
        run_steps("jump", 6);
    endtask

    task automatic test_branch();
        begin_test();
        prog_mem[0] = addi_inst(5'd1, 5'd0, 12'd5);
        prog_mem[1] = addi_inst(5'd2, 5'd0, 12'd5);
        prog_mem[2] = addi_inst(5'd3, 5'd0, 12'd7);
        prog_mem[3] = bne_inst(5'd1, 5'd2, 13'd12);  // equal, falls through
        prog_mem[4] = bne_inst(5'd1, 5'd3, 13'd8);
        prog_mem[5] = addi_inst(5'd4, 5'd0, 12'd4);
        prog_mem[6] = addi_inst(5'd5, 5'd0, 12'd1);
        release_reset();
        run_steps("branch", 6);
    endtask

    task automatic test_illegal();
        begin_test();
        prog_mem[0] = addi_inst(5'd1, 5'd0, 12'd9);
        prog_mem[1] = 32'h0000_00ff;
        prog_mem[2] = {12'd4, 5'd1, 3'b010, 5'd2, 7'b0010011};  // slti
        prog_mem[3] = alu_inst(7'h01, 5'd3, 5'd1, 5'd1);  // mul
        prog_mem[4] = {7'd0, 5'd1, 5'd1, 3'b000, 5'd8, 7'b1100011};  // beq
        prog_mem[5] = 32'h0000_0073;  // ecall
        prog_mem[6] = alu_inst(rv_pkg::funct7_add, 5'd4, 5'd1, 5'd0);
        prog_mem[7] = alu_inst(rv_pkg::funct7_add, 5'd5, 5'd2, 5'd3);
        release_reset();
        run_steps("illegal", 8);
    endtask

    task automatic test_halt();
        begin_test();
        prog_mem[0] = addi_inst(5'd1, 5'd0, 12'd3);
        prog_mem[1] = 32'h0010_0073;  // ebreak
        prog_mem[2] = addi_inst(5'd2, 5'd0, 12'd1);
        release_reset();
        run_steps("halt", 2);
        // held word now asks for a write and no longer requests halt
        prog_mem[1] = addi_inst(5'd3, 5'd1, 12'd4);
        @(negedge clk);
        run_steps("halt", 9);  // ten held cycles in all
        begin_test();
        release_reset();
        check_pc("halt reset", `RV_RESET_PC, pc);
        check_flag("halt reset halted", 1'b0, halted);
    endtask

    initial begin
        int assert_fails;
        reset       = 1'b1;
        error_count = 0;
        clear_program();
        void'($urandom(32'h9593));
        test_arith();
        test_upper();
        test_jump();
        test_branch();
        test_illegal();
        test_halt();
        assert_fails = i_dut.i_checker.fail_count;
        $display("errors: %0d compare, %0d assertion", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
